// File: design/lx_bus_pkg.sv
// lx bus bridge package: message codes, line and beat geometry, shared payload types
package lx_bus_pkg;

  // data and address geometry
  localparam int word_width    = 32;
  localparam int address_width = 32;

  localparam int line_words       = 4;  // words per cache line
  localparam int line_offset_bits = 2;  // word offset inside a line address

  localparam int bus_words       = 2;   // words per bus beat
  localparam int line_beats      = line_words / bus_words;
  localparam int beat_index_bits = 1;   // enough to count line_beats

  // message codes seen on both the bus and the cache side
  typedef enum logic [3:0] {
    NO_REQ     = 4'd0,
    R_REQ      = 4'd1,   // full-line read
    WB_REQ     = 4'd2,   // full-line write-back
    MEM_RESP   = 4'd3,
    MEM_RESP_S = 4'd4    // read response, line held shared
  } msg_t;

  typedef logic [address_width-1:0] addr_t;

  // word 0 sits in the low bits of both
  typedef logic [bus_words*word_width-1:0]  beat_t;
  typedef logic [line_words*word_width-1:0] line_t;

endpackage

// File: design/bridge_ctrl.sv
// bridge controller: request FSM that sequences bus beats and cache accesses
module bridge_ctrl (
  input  logic                                  clock,
  input  logic                                  reset,
  input  lx_bus_pkg::msg_t                      bus_msg_in,
  input  logic                                  req_ready,
  input  lx_bus_pkg::msg_t                      cache_msg_in,
  output logic                                  accept,
  output logic                                  beat_write,
  output logic                                  line_load,
  output logic [lx_bus_pkg::beat_index_bits-1:0] beat_index,
  output logic                                  bus_load,
  output logic                                  bus_clear,
  output logic                                  cache_load,
  output logic                                  cache_clear,
  output lx_bus_pkg::msg_t                      bus_msg_next,
  output lx_bus_pkg::msg_t                      cache_msg_next
);
  import lx_bus_pkg::*;

  typedef enum logic [2:0] {
    idle,
    fetch,           // first cycle of R_REQ on the cache side
    read_wait,
    transfer,        // remaining beats of a read go out
    receive,         // beats of a write-back come in
    write_wait,
    bus_clear_wait
  } state_t;

  state_t                     state;
  logic [beat_index_bits-1:0] beat_count;
  logic                       is_read;
  msg_t                       resp_code;    // cache response forwarded with later beats

  logic read_req;
  logic bus_req;
  logic cache_resp;
  logic last_beat;

  assign read_req   = bus_msg_in == R_REQ;
  assign bus_req    = read_req | (bus_msg_in == WB_REQ);
  assign cache_resp = (cache_msg_in == MEM_RESP) | (cache_msg_in == MEM_RESP_S);
  assign last_beat  = beat_count == beat_index_bits'(line_beats - 1);
  assign beat_index = beat_count;

  // only a write-back loads the cache port from the receive state
  assign cache_msg_next = (state == receive) ? WB_REQ : R_REQ;
  assign bus_msg_next   = (state == transfer) ? resp_code : cache_msg_in;

  always_comb begin
    accept      = 1'b0;
    beat_write  = 1'b0;
    line_load   = 1'b0;
    bus_load    = 1'b0;
    bus_clear   = 1'b0;
    cache_load  = 1'b0;
    cache_clear = 1'b0;
    case (state)
      idle: begin
        accept     = req_ready & bus_req;
        cache_load = req_ready & read_req;  // R_REQ goes out on the accept edge
      end
      fetch, read_wait: begin
        // capture the line and put beat 0 on the bus in the same edge
        line_load   = cache_resp;
        bus_load    = cache_resp;
        cache_clear = cache_resp;
      end
      transfer: bus_load = 1'b1;
      receive: begin
        beat_write = 1'b1;
        cache_load = last_beat;  // line buffer passes the last beat straight through
      end
      write_wait: begin
        cache_clear = cache_msg_in == MEM_RESP;
        bus_load    = cache_msg_in == MEM_RESP;  // completion to the bus master
      end
      bus_clear_wait: bus_clear = is_read | (bus_msg_in == NO_REQ);  // read beats end at once
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= idle;
      beat_count <= '0;
      is_read    <= 1'b0;
      resp_code  <= NO_REQ;
    end else begin
      case (state)
        idle: begin
          if (accept) begin
            is_read <= read_req;
            state   <= read_req ? fetch : receive;
          end
        end
        fetch, read_wait: begin
          if (cache_resp) begin
            resp_code  <= cache_msg_in;
            beat_count <= beat_count + 1'b1;  // beat 0 already loaded
            state      <= transfer;
          end else begin
            state <= read_wait;
          end
        end
        transfer, receive: begin
          beat_count <= last_beat ? '0 : beat_count + 1'b1;
          if (last_beat) begin
            state <= (state == transfer) ? bus_clear_wait : write_wait;
          end
        end
        write_wait: begin
          if (cache_msg_in == MEM_RESP) state <= bus_clear_wait;
        end
        bus_clear_wait: begin
          if (bus_msg_in == NO_REQ) state <= idle;  // master has released its request
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

// File: design/line_buffer.sv
// line buffer: one cache line, written by bus beat or whole line, read as beat or line
module line_buffer (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic                                   beat_write,
  input  logic                                   line_load,
  input  logic [lx_bus_pkg::beat_index_bits-1:0] beat_index,
  input  lx_bus_pkg::beat_t                      bus_data_in,
  input  lx_bus_pkg::line_t                      cache_data_in,
  output lx_bus_pkg::line_t                      line,
  output lx_bus_pkg::beat_t                      beat
);
  import lx_bus_pkg::*;

  localparam int beat_bits = $bits(beat_t);

  line_t line_q;
  line_t line_next;

  // a whole line from the cache wins over a bus beat
  always_comb begin
    line_next = line_q;
    if (line_load) begin
      line_next = cache_data_in;
    end else if (beat_write) begin
      line_next[beat_index*beat_bits +: beat_bits] = bus_data_in;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      line_q <= '0;
    end else begin
      line_q <= line_next;
    end
  end

  // outputs show the value being written this cycle, so the ports can
  // register a freshly arrived line or last beat on the same edge
  assign line = line_next;
  assign beat = line_next[beat_index*beat_bits +: beat_bits];

endmodule

// File: design/bus_port.sv
// bus port: output registers for bus message, request address and data beat
module bus_port (
  input  logic                clock,
  input  logic                reset,
  input  logic                accept,
  input  lx_bus_pkg::addr_t   bus_address_in,
  input  logic                bus_load,
  input  logic                bus_clear,
  input  lx_bus_pkg::msg_t    bus_msg_next,
  input  lx_bus_pkg::beat_t   beat,
  output lx_bus_pkg::msg_t    bus_msg_out,
  output lx_bus_pkg::addr_t   bus_address_out,
  output lx_bus_pkg::beat_t   bus_data_out
);
  import lx_bus_pkg::*;

  addr_t req_address;  // request address held for the whole transaction

  always_ff @(posedge clock) begin
    if (accept) req_address <= bus_address_in;
  end

  always_ff @(posedge clock) begin
    if (reset || bus_clear) begin
      bus_msg_out     <= NO_REQ;
      bus_address_out <= '0;
      bus_data_out    <= '0;
    end else if (bus_load) begin
      bus_msg_out     <= bus_msg_next;
      bus_address_out <= req_address;
      bus_data_out    <= beat;
    end
  end

endmodule

// File: design/cache_port.sv
// cache port: output registers for cache message, line-aligned address and line data
module cache_port (
  input  logic                clock,
  input  logic                reset,
  input  logic                accept,
  input  lx_bus_pkg::addr_t   bus_address_in,
  input  logic                cache_load,
  input  logic                cache_clear,
  input  lx_bus_pkg::msg_t    cache_msg_next,
  input  lx_bus_pkg::line_t   line,
  output lx_bus_pkg::msg_t    cache_msg_out,
  output lx_bus_pkg::addr_t   cache_address_out,
  output lx_bus_pkg::line_t   cache_data_out
);
  import lx_bus_pkg::*;

  addr_t line_address;  // line-aligned request address held for the transaction

  always_ff @(posedge clock) begin
    if (accept) line_address <= {bus_address_in[address_width-1:line_offset_bits],
                                 {line_offset_bits{1'b0}}};
  end

  addr_t load_address;
  assign load_address = accept ? {bus_address_in[address_width-1:line_offset_bits],
                                  {line_offset_bits{1'b0}}}
                               : line_address;

  always_ff @(posedge clock) begin
    if (reset || cache_clear) begin
      cache_msg_out     <= NO_REQ;
      cache_address_out <= '0;
      cache_data_out    <= '0;
    end else if (cache_load) begin
      cache_msg_out     <= cache_msg_next;
      cache_address_out <= load_address;
      cache_data_out    <= line;
    end
  end

endmodule

// File: design/lx_bus_bridge.sv
// lx bus bridge top: controller plus line buffer, bus port and cache port
module lx_bus_bridge (
  input  logic                clock,
  input  logic                reset,
  input  lx_bus_pkg::msg_t    bus_msg_in,
  input  lx_bus_pkg::addr_t   bus_address_in,
  input  lx_bus_pkg::beat_t   bus_data_in,
  input  logic                req_ready,
  output lx_bus_pkg::msg_t    bus_msg_out,
  output lx_bus_pkg::addr_t   bus_address_out,
  output lx_bus_pkg::beat_t   bus_data_out,
  input  lx_bus_pkg::msg_t    cache_msg_in,
  input  lx_bus_pkg::line_t   cache_data_in,
  output lx_bus_pkg::msg_t    cache_msg_out,
  output lx_bus_pkg::addr_t   cache_address_out,
  output lx_bus_pkg::line_t   cache_data_out
);
  import lx_bus_pkg::*;

  logic                       accept;
  logic                       beat_write;
  logic                       line_load;
  logic [beat_index_bits-1:0] beat_index;
  logic                       bus_load;
  logic                       bus_clear;
  logic                       cache_load;
  logic                       cache_clear;
  msg_t                       bus_msg_next;
  msg_t                       cache_msg_next;
  line_t                      line;
  beat_t                      beat;

  bridge_ctrl ctrl0 (
    .clock          (clock),
    .reset          (reset),
    .bus_msg_in     (bus_msg_in),
    .req_ready      (req_ready),
    .cache_msg_in   (cache_msg_in),
    .accept         (accept),
    .beat_write     (beat_write),
    .line_load      (line_load),
    .beat_index     (beat_index),
    .bus_load       (bus_load),
    .bus_clear      (bus_clear),
    .cache_load     (cache_load),
    .cache_clear    (cache_clear),
    .bus_msg_next   (bus_msg_next),
    .cache_msg_next (cache_msg_next)
  );

  line_buffer buffer0 (
    .clock         (clock),
    .reset         (reset),
    .beat_write    (beat_write),
    .line_load     (line_load),
    .beat_index    (beat_index),
    .bus_data_in   (bus_data_in),
    .cache_data_in (cache_data_in),
    .line          (line),
    .beat          (beat)
  );

  bus_port bus0 (
    .clock           (clock),
    .reset           (reset),
    .accept          (accept),
    .bus_address_in  (bus_address_in),
    .bus_load        (bus_load),
    .bus_clear       (bus_clear),
    .bus_msg_next    (bus_msg_next),
    .beat            (beat),
    .bus_msg_out     (bus_msg_out),
    .bus_address_out (bus_address_out),
    .bus_data_out    (bus_data_out)
  );

  cache_port cache0 (
    .clock             (clock),
    .reset             (reset),
    .accept            (accept),
    .bus_address_in    (bus_address_in),
    .cache_load        (cache_load),
    .cache_clear       (cache_clear),
    .cache_msg_next    (cache_msg_next),
    .line              (line),
    .cache_msg_out     (cache_msg_out),
    .cache_address_out (cache_address_out),
    .cache_data_out    (cache_data_out)
  );

endmodule

// File: testbench/tb_lx_bus_bridge.sv
// lx bus bridge testbench with random reads and write-backs against cache and bus models
module tb_lx_bus_bridge;
  import lx_bus_pkg::*;

  localparam int transactions = 40;
  localparam int cycle_limit  = transactions * 30;
  localparam int drive_delay  = 5;   // inputs change this long after the rising edge
  localparam int beat_bits    = $bits(beat_t);

  logic  clock;
  logic  reset;
  msg_t  bus_msg_in;
  addr_t bus_address_in;
  beat_t bus_data_in;
  logic  req_ready;
  msg_t  bus_msg_out;
  addr_t bus_address_out;
  beat_t bus_data_out;
  msg_t  cache_msg_in;
  line_t cache_data_in;
  msg_t  cache_msg_out;
  addr_t cache_address_out;
  line_t cache_data_out;

  // expected outputs for the current cycle
  msg_t  exp_bus_msg;
  addr_t exp_bus_address;
  beat_t exp_bus_data;
  logic  check_bus_data;
  msg_t  exp_cache_msg;
  addr_t exp_cache_address;
  line_t exp_cache_data;
  logic  check_cache_data;

  logic [15:0] lfsr_state;
  int          mismatches;
  int          other_errors;

  lx_bus_bridge dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // fibonacci lfsr with taps 16 14 13 11
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    logic        feedback;
    int          i;
    value = '0;
    for (i = 0; i < count; i++) begin
      feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], feedback};
      value      = {value[30:0], feedback};
    end
    return value;
  endfunction

  function automatic addr_t line_aligned(input addr_t address);
    return address & ~addr_t'((1 << line_offset_bits) - 1);
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #drive_delay;
  endtask

  task automatic expect_bus_idle();
    exp_bus_msg     = NO_REQ;
    exp_bus_address = '0;
    exp_bus_data    = '0;
    check_bus_data  = 1'b1;
  endtask

  task automatic expect_cache_idle();
    exp_cache_msg     = NO_REQ;
    exp_cache_address = '0;
    exp_cache_data    = '0;
    check_cache_data  = 1'b1;
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
    mismatches++;
    $display("FAILED %s expected %0h actual %0h at %0t", name, expected, actual, $time);
  endtask

  task automatic print_counts();
    $display("errors: %0d value mismatches, %0d other failures", mismatches, other_errors);
  endtask

  bus_msg_check: assert property (@(posedge clock) disable iff (reset)
      bus_msg_out == exp_bus_msg)
    else report_mismatch("bus_msg_out", 128'($sampled(exp_bus_msg)),
                         128'($sampled(bus_msg_out)));
  bus_address_check: assert property (@(posedge clock) disable iff (reset)
      bus_address_out == exp_bus_address)
    else report_mismatch("bus_address_out", 128'($sampled(exp_bus_address)),
                         128'($sampled(bus_address_out)));
  bus_data_check: assert property (@(posedge clock) disable iff (reset)
      !check_bus_data || bus_data_out == exp_bus_data)
    else report_mismatch("bus_data_out", 128'($sampled(exp_bus_data)),
                         128'($sampled(bus_data_out)));
  cache_msg_check: assert property (@(posedge clock) disable iff (reset)
      cache_msg_out == exp_cache_msg)
    else report_mismatch("cache_msg_out", 128'($sampled(exp_cache_msg)),
                         128'($sampled(cache_msg_out)));
  cache_address_check: assert property (@(posedge clock) disable iff (reset)
      cache_address_out == exp_cache_address)
    else report_mismatch("cache_address_out", 128'($sampled(exp_cache_address)),
                         128'($sampled(cache_address_out)));
  cache_data_check: assert property (@(posedge clock) disable iff (reset)
      !check_cache_data || cache_data_out == exp_cache_data)
    else report_mismatch("cache_data_out", $sampled(exp_cache_data),
                         $sampled(cache_data_out));

  // runs from the acceptance cycle to the first idle cycle after it
  task automatic read_transaction(input addr_t address);
    int    latency;
    int    release_delay;
    int    last_cycle;
    int    n;
    msg_t  resp;
    line_t line;
    latency       = int'(random_bits(3));
    release_delay = int'(random_bits(2));
    resp          = (random_bits(1) != 0) ? MEM_RESP_S : MEM_RESP;
    for (n = 0; n < line_words; n++) begin
      line[n*word_width +: word_width] = {address[31:16], 16'(n)};  // cache model line
    end
    req_ready = 1'b1;
    next_cycle();
    req_ready         = random_bits(1) != 0;
    bus_address_in    = ~address;  // address only valid in the acceptance cycle
    exp_cache_msg     = R_REQ;
    exp_cache_address = line_aligned(address);
    check_cache_data  = 1'b0;  // line data means nothing on a read request
    repeat (latency) next_cycle();
    cache_msg_in  = resp;
    cache_data_in = line;
    last_cycle = (release_delay + 1 > line_beats) ? release_delay + 1 : line_beats;
    for (n = 1; n <= last_cycle + 1; n++) begin
      next_cycle();
      if (n == 1) begin
        cache_msg_in  = NO_REQ;  // cache has seen its request drop
        cache_data_in = ~line;   // line must come from the buffer now
        expect_cache_idle();
      end
      if (n <= line_beats) begin
        exp_bus_msg     = resp;
        exp_bus_address = address;
        exp_bus_data    = line[(n-1)*beat_bits +: beat_bits];
      end else begin
        expect_bus_idle();
      end
      if (n == release_delay + 1) bus_msg_in = NO_REQ;
    end
  endtask

  task automatic write_transaction(input addr_t address);
    int    latency;
    int    release_delay;
    int    k;
    line_t line;
    latency       = int'(random_bits(3));
    release_delay = int'(random_bits(2));
    for (k = 0; k < line_words; k++) begin
      line[k*word_width +: word_width] = random_bits(32);
    end
    req_ready = 1'b1;
    for (k = 0; k < line_beats; k++) begin
      next_cycle();
      bus_data_in    = line[k*beat_bits +: beat_bits];  // beat 0 first
      bus_address_in = ~address;  // address only valid in the acceptance cycle
    end
    next_cycle();
    exp_cache_msg     = WB_REQ;
    exp_cache_address = line_aligned(address);
    exp_cache_data    = line;
    check_cache_data  = 1'b1;
    repeat (latency) next_cycle();
    cache_msg_in = MEM_RESP;
    next_cycle();
    cache_msg_in = NO_REQ;
    expect_cache_idle();
    exp_bus_msg     = MEM_RESP;
    exp_bus_address = address;
    check_bus_data  = 1'b0;
    repeat (release_delay) next_cycle();
    bus_msg_in = NO_REQ;  // master saw the completion
    next_cycle();
    expect_bus_idle();
  endtask

  initial begin
    addr_t address;
    int    gap;
    int    t;
    logic  is_read;
    lfsr_state     = 16'd56330;
    mismatches     = 0;
    other_errors   = 0;
    reset          = 1'b1;
    bus_msg_in     = NO_REQ;
    bus_address_in = '0;
    bus_data_in    = '0;
    req_ready      = 1'b0;
    cache_msg_in   = NO_REQ;
    cache_data_in  = '0;
    expect_bus_idle();
    expect_cache_idle();
    repeat (16) next_cycle();
    reset = 1'b0;
    repeat (3) next_cycle();
    for (t = 0; t < transactions; t++) begin
      address        = random_bits(32);
      gap            = int'(random_bits(2));
      is_read        = random_bits(1) != 0;
      bus_msg_in     = is_read ? R_REQ : WB_REQ;
      bus_address_in = address;
      req_ready      = 1'b0;
      repeat (gap) next_cycle();  // request waits on req_ready
      if (is_read) read_transaction(address);
      else write_transaction(address);
    end
    next_cycle();
    print_counts();
    if (mismatches + other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clock);
      cycles++;
    end
    other_errors++;
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    print_counts();
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: compile.f
design/lx_bus_pkg.sv
design/bridge_ctrl.sv
design/line_buffer.sv
design/bus_port.sv
design/cache_port.sv
design/lx_bus_bridge.sv
testbench/tb_lx_bus_bridge.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lx_bus_bridge
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
